// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_encrypter -f sources.f
	out=$$(./obj_dir/Vtb_encrypter); echo "$$out"; echo "$$out" | grep -q "NO ERRORS"

clean:
	rm -rf obj_dir

// File: ct_compressor.sv
`timescale 1ns/1ps
`default_nettype none

module ct_compressor
    import encrypt_pkg::*;
#(
    parameter int N = 1024
) (
    input  wire logic   clk,
    input  wire logic   rst,
    input  wire logic   start,
    input  wire coeff_t v_rdata,
    output addr_t       v_raddr,
    output logic        out_we,
    output addr_t       out_waddr,
    output byte_t       out_wdata,
    output logic        done
);

    localparam int acc_w = 8 + comp_bits;          // 7 pending plus one new value
    localparam int last_byte = comp_bits * N / 8 - 1;

    logic                         running;
    logic                         rd_valid;
    logic                         out_last;
    addr_t                        byte_cnt;
    logic [acc_w-1:0]             acc;
    logic [acc_w-1:0]             acc_next;
    logic [3:0]                   pend;
    logic [3:0]                   pend_next;
    logic [coeff_w+comp_bits-1:0] scaled;
    logic [31:0]                  quot;
    logic [comp_bits-1:0]         level;

    ////////////////////////////////////////////////////////////
    // rounding and bit accumulator
    ////////////////////////////////////////////////////////////

    always_comb begin
        scaled = {v_rdata, comp_bits'(0)} + (coeff_w + comp_bits)'(q_half);
        quot = 32'(scaled) / q;
        level = quot[comp_bits-1:0];   // mod 8 by truncation
        acc_next = acc | (acc_w'(level) << pend);   // lsb first
        pend_next = pend + 4'(comp_bits);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            running <= 1'b0;
            v_raddr <= '0;
            rd_valid <= 1'b0;
            acc <= '0;
            pend <= '0;
            byte_cnt <= '0;
            out_we <= 1'b0;
            out_last <= 1'b0;
            done <= 1'b0;
        end else begin
            rd_valid <= running;
            out_we <= 1'b0;
            out_last <= 1'b0;
            done <= out_last;
            if (running) begin
                if (v_raddr == addr_t'(N - 1)) begin
                    running <= 1'b0;
                    v_raddr <= '0;
                end else begin
                    v_raddr <= v_raddr + 1'b1;
                end
            end else if (start) begin
                running <= 1'b1;
            end
            if (rd_valid) begin
                if (pend_next >= 4'd8) begin
                    out_we <= 1'b1;
                    out_waddr <= byte_cnt;
                    out_wdata <= acc_next[7:0];
                    out_last <= (byte_cnt == addr_t'(last_byte));
                    byte_cnt <= (byte_cnt == addr_t'(last_byte)) ? '0 : byte_cnt + 1'b1;
                    acc <= acc_next >> 8;
                    pend <= pend_next - 4'd8;
                end else begin
                    acc <= acc_next;
                    pend <= pend_next;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: dp_ram.sv
`timescale 1ns/1ps
`default_nettype none

module dp_ram
    import encrypt_pkg::*;
#(
    parameter int WIDTH = 8,
    parameter int DEPTH = 256
) (
    input  wire logic             clk,
    input  wire logic             we,
    input  wire addr_t            waddr,
    input  wire logic [WIDTH-1:0] wdata,
    input  wire addr_t            raddr,
    output logic      [WIDTH-1:0] rdata
);

    // index width, at least one bit for a single-entry memory
    localparam int aw = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [WIDTH-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr[aw-1:0]] <= wdata;
        end
    end

    // read data one cycle after the address
    always_ff @(posedge clk) begin
        rdata <= mem[raddr[aw-1:0]];
    end

endmodule

`default_nettype wire

// File: encrypt_pkg.sv
`default_nettype none

package encrypt_pkg;

    ////////////////////////////////////////////////////////////
    // field constants
    ////////////////////////////////////////////////////////////

    localparam int unsigned q = 12289;
    localparam int unsigned q_half = q / 2;   // encoded value of a set message bit
    localparam int coeff_w = 14;
    localparam int comp_bits = 3;             // bits per compressed coefficient
    localparam int max_addr_w = 11;           // 2N bytes at N = 1024

    typedef logic [coeff_w-1:0] coeff_t;
    typedef logic [7:0] byte_t;
    typedef logic [31:0] word_t;
    typedef logic [max_addr_w-1:0] addr_t;

    // one write into a polynomial bank
    typedef struct packed {
        logic   enable;
        addr_t  addr;
        coeff_t data;
    } poly_wr_t;

    typedef enum logic [2:0] {
        seq_idle,
        seq_load,    // decoder and message encoder
        seq_add,
        seq_pack,
        seq_finish
    } seq_state_t;

endpackage

`default_nettype wire

// File: encrypt_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module encrypt_sequencer
    import encrypt_pkg::*;
(
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic start,
    input  wire logic decode_done,
    input  wire logic encode_done,
    input  wire logic add_done,
    input  wire logic pack_done,
    output logic      start_decode,
    output logic      start_encode,
    output logic      start_add,
    output logic      start_pack,
    output logic      busy,
    output logic      done
);

    seq_state_t state;
    logic       got_decode;
    logic       got_encode;
    logic       got_add;
    logic       got_pack;
    logic       phase_done;

    // join of the units running in the current phase
    always_comb begin
        case (state)
            seq_load: phase_done = got_decode && got_encode;
            seq_add:  phase_done = got_add;
            seq_pack: phase_done = got_pack;
            default:  phase_done = 1'b0;
        endcase
    end

    assign busy = (state != seq_idle);

    ////////////////////////////////////////////////////////////
    // phase FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        start_decode <= 1'b0;
        start_encode <= 1'b0;
        start_add <= 1'b0;
        start_pack <= 1'b0;
        done <= 1'b0;
        if (rst) begin
            state <= seq_idle;
            got_decode <= 1'b0;
            got_encode <= 1'b0;
            got_add <= 1'b0;
            got_pack <= 1'b0;
        end else begin
            if (decode_done) got_decode <= 1'b1;
            if (encode_done) got_encode <= 1'b1;
            if (add_done) got_add <= 1'b1;
            if (pack_done) got_pack <= 1'b1;
            if (phase_done) begin
                got_decode <= 1'b0;
                got_encode <= 1'b0;
                got_add <= 1'b0;
                got_pack <= 1'b0;
            end
            case (state)
                seq_idle: begin
                    if (start) begin
                        state <= seq_load;
                        start_decode <= 1'b1;
                        start_encode <= 1'b1;
                    end
                end
                seq_load: begin
                    if (phase_done) begin
                        state <= seq_add;
                        start_add <= 1'b1;
                    end
                end
                seq_add: begin
                    if (phase_done) begin
                        state <= seq_pack;
                        start_pack <= 1'b1;
                    end
                end
                seq_pack: begin
                    if (phase_done) begin
                        state <= seq_finish;
                        done <= 1'b1;   // high during the finish cycle
                    end
                end
                default: state <= seq_idle;   // finish lasts one cycle
            endcase
        end
    end

endmodule

`default_nettype wire

// File: encrypter.sv
`timescale 1ns/1ps
`default_nettype none

module encrypter
    import encrypt_pkg::*;
#(
    parameter int N = 1024
) (
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire logic  start,
    input  wire logic  ct_we,
    input  wire addr_t ct_addr,
    input  wire byte_t ct_data,
    input  wire logic  msg_we,
    input  wire addr_t msg_addr,
    input  wire word_t msg_data,
    input  wire addr_t out_addr,
    output byte_t      out_data,
    output logic       busy,
    output logic       done
);

    addr_t    ct_raddr;
    byte_t    ct_rdata;
    addr_t    msg_raddr;
    word_t    msg_rdata;
    poly_wr_t u_wr;
    poly_wr_t m_wr;
    poly_wr_t v_wr;
    addr_t    add_raddr;
    coeff_t   u_rdata;
    coeff_t   m_rdata;
    addr_t    v_raddr;
    coeff_t   v_rdata;
    logic     out_we;
    addr_t    out_waddr;
    byte_t    out_wdata;
    logic     start_decode, start_encode, start_add, start_pack;
    logic     decode_done, encode_done, add_done, pack_done;

    ////////////////////////////////////////////////////////////
    // memories, one writer and one reader each
    ////////////////////////////////////////////////////////////

    dp_ram #(.WIDTH(8), .DEPTH(2 * N)) ct_ram (
        .clk(clk), .we(ct_we), .waddr(ct_addr), .wdata(ct_data),
        .raddr(ct_raddr), .rdata(ct_rdata)
    );

    dp_ram #(.WIDTH(32), .DEPTH(N / 32)) msg_ram (
        .clk(clk), .we(msg_we), .waddr(msg_addr), .wdata(msg_data),
        .raddr(msg_raddr), .rdata(msg_rdata)
    );

    dp_ram #(.WIDTH(coeff_w), .DEPTH(N)) u_bank (
        .clk(clk), .we(u_wr.enable), .waddr(u_wr.addr), .wdata(u_wr.data),
        .raddr(add_raddr), .rdata(u_rdata)
    );

    dp_ram #(.WIDTH(coeff_w), .DEPTH(N)) m_bank (
        .clk(clk), .we(m_wr.enable), .waddr(m_wr.addr), .wdata(m_wr.data),
        .raddr(add_raddr), .rdata(m_rdata)
    );

    dp_ram #(.WIDTH(coeff_w), .DEPTH(N)) v_bank (
        .clk(clk), .we(v_wr.enable), .waddr(v_wr.addr), .wdata(v_wr.data),
        .raddr(v_raddr), .rdata(v_rdata)
    );

    dp_ram #(.WIDTH(8), .DEPTH(comp_bits * N / 8)) out_ram (
        .clk(clk), .we(out_we), .waddr(out_waddr), .wdata(out_wdata),
        .raddr(out_addr), .rdata(out_data)   // host read port
    );

    ////////////////////////////////////////////////////////////
    // units and sequencer
    ////////////////////////////////////////////////////////////

    poly_decoder #(.N(N)) decoder (
        .clk(clk), .rst(rst), .start(start_decode), .ct_rdata(ct_rdata),
        .ct_raddr(ct_raddr), .wr(u_wr), .done(decode_done)
    );

    message_encoder #(.N(N)) encoder (
        .clk(clk), .rst(rst), .start(start_encode), .msg_rdata(msg_rdata),
        .msg_raddr(msg_raddr), .wr(m_wr), .done(encode_done)
    );

    poly_adder #(.N(N)) adder (
        .clk(clk), .rst(rst), .start(start_add), .a_rdata(u_rdata), .b_rdata(m_rdata),
        .raddr(add_raddr), .wr(v_wr), .done(add_done)
    );

    ct_compressor #(.N(N)) compressor (
        .clk(clk), .rst(rst), .start(start_pack), .v_rdata(v_rdata),
        .v_raddr(v_raddr), .out_we(out_we), .out_waddr(out_waddr),
        .out_wdata(out_wdata), .done(pack_done)
    );

    encrypt_sequencer sequencer (
        .clk(clk), .rst(rst), .start(start),
        .decode_done(decode_done), .encode_done(encode_done),
        .add_done(add_done), .pack_done(pack_done),
        .start_decode(start_decode), .start_encode(start_encode),
        .start_add(start_add), .start_pack(start_pack),
        .busy(busy), .done(done)
    );

endmodule

`default_nettype wire

// File: message_encoder.sv
`timescale 1ns/1ps
`default_nettype none

module message_encoder
    import encrypt_pkg::*;
#(
    parameter int N = 1024
) (
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire logic  start,
    input  wire word_t msg_rdata,
    output addr_t      msg_raddr,
    output poly_wr_t   wr,
    output logic       done
);

    logic  running;
    logic  fetch;       // waiting for the first word
    logic  wr_last;
    addr_t idx;
    word_t shreg;

    always_ff @(posedge clk) begin
        wr.addr <= idx;
        wr.data <= shreg[0] ? coeff_t'(q_half) : '0;
        if (rst) begin
            running <= 1'b0;
            fetch <= 1'b0;
            idx <= '0;
            msg_raddr <= '0;
            wr.enable <= 1'b0;
            wr_last <= 1'b0;
            done <= 1'b0;
        end else begin
            wr.enable <= running && !fetch;
            wr_last <= running && !fetch && (idx == addr_t'(N - 1));
            done <= wr_last;
            if (fetch) begin
                // word 0 was read while idle at address 0
                shreg <= msg_rdata;
                fetch <= 1'b0;
                msg_raddr <= msg_raddr + 1'b1;
            end else if (running) begin
                idx <= idx + 1'b1;
                shreg <= shreg >> 1;
                if (idx[4:0] == 5'd31) begin
                    shreg <= msg_rdata;   // next word, requested 32 cycles ago
                    msg_raddr <= msg_raddr + 1'b1;
                end
                if (idx == addr_t'(N - 1)) begin
                    running <= 1'b0;
                    idx <= '0;
                    msg_raddr <= '0;
                end
            end else if (start) begin
                running <= 1'b1;
                fetch <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: poly_adder.sv
`timescale 1ns/1ps
`default_nettype none

module poly_adder
    import encrypt_pkg::*;
#(
    parameter int N = 1024
) (
    input  wire logic   clk,
    input  wire logic   rst,
    input  wire logic   start,
    input  wire coeff_t a_rdata,
    input  wire coeff_t b_rdata,
    output addr_t       raddr,
    output poly_wr_t    wr,
    output logic        done
);

    logic             running;
    logic             rd_valid;
    logic             rd_last;
    addr_t            rd_addr;
    logic             wr_last;
    logic [coeff_w:0] sum;
    logic [coeff_w:0] sum_red;

    assign sum = {1'b0, a_rdata} + {1'b0, b_rdata};
    assign sum_red = (sum >= q) ? sum - (coeff_w + 1)'(q) : sum;

    // address sweep, same address to both banks
    always_ff @(posedge clk) begin
        if (rst) begin
            running <= 1'b0;
            raddr <= '0;
        end else if (running) begin
            if (raddr == addr_t'(N - 1)) begin
                running <= 1'b0;
                raddr <= '0;
            end else begin
                raddr <= raddr + 1'b1;
            end
        end else if (start) begin
            running <= 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // valid pipeline, read stage then write stage
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        rd_addr <= raddr;
        wr.addr <= rd_addr;
        wr.data <= sum_red[coeff_w-1:0];
        if (rst) begin
            rd_valid <= 1'b0;
            rd_last <= 1'b0;
            wr.enable <= 1'b0;
            wr_last <= 1'b0;
            done <= 1'b0;
        end else begin
            rd_valid <= running;
            rd_last <= running && (raddr == addr_t'(N - 1));
            wr.enable <= rd_valid;
            wr_last <= rd_valid && rd_last;
            done <= wr_last;
        end
    end

endmodule

`default_nettype wire

// File: poly_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module poly_decoder
    import encrypt_pkg::*;
#(
    parameter int N = 1024
) (
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire logic  start,
    input  wire byte_t ct_rdata,
    output addr_t      ct_raddr,
    output poly_wr_t   wr,
    output logic       done
);

    logic   running;
    logic   rd_valid;
    logic   rd_high;     // byte in flight is the high byte
    logic   rd_last;
    addr_t  rd_idx;
    byte_t  low_byte;
    logic   wr_last;
    coeff_t raw;

    // 14 bits from the byte pair, high byte on top
    assign raw = {ct_rdata[coeff_w-9:0], low_byte};

    ////////////////////////////////////////////////////////////
    // byte sweep, one address per cycle
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            running <= 1'b0;
            ct_raddr <= '0;
            rd_valid <= 1'b0;
            rd_last <= 1'b0;
        end else begin
            rd_valid <= running;
            rd_last <= running && (ct_raddr == addr_t'(2 * N - 1));
            if (running) begin
                if (ct_raddr == addr_t'(2 * N - 1)) begin
                    running <= 1'b0;
                    ct_raddr <= '0;
                end else begin
                    ct_raddr <= ct_raddr + 1'b1;
                end
            end else if (start) begin
                running <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        rd_high <= ct_raddr[0];
        rd_idx <= {1'b0, ct_raddr[max_addr_w-1:1]};   // coefficient index
        if (rd_valid && !rd_high) begin
            low_byte <= ct_rdata;
        end
    end

    ////////////////////////////////////////////////////////////
    // assemble, reduce and write
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        wr.addr <= rd_idx;
        wr.data <= (raw >= q) ? raw - coeff_t'(q) : raw;   // one subtraction is enough
        if (rst) begin
            wr.enable <= 1'b0;
            wr_last <= 1'b0;
            done <= 1'b0;
        end else begin
            wr.enable <= rd_valid && rd_high;
            wr_last <= rd_valid && rd_last;
            done <= wr_last;
        end
    end

endmodule

`default_nettype wire

// File: sources.f
encrypt_pkg.sv
dp_ram.sv
poly_decoder.sv
message_encoder.sv
poly_adder.sv
ct_compressor.sv
encrypt_sequencer.sv
encrypter.sv
tb_encrypter.sv
tb_encrypter_assertions.sv

// File: tb_encrypter.sv
`timescale 1ns/1ps
`default_nettype none

module tb_encrypter
    import encrypt_pkg::*;
();

    localparam int n = 64;
    localparam int n_out = comp_bits * n / 8;

    logic  clk;
    logic  rst;
    logic  start;
    logic  ct_we;
    addr_t ct_addr;
    byte_t ct_data;
    logic  msg_we;
    addr_t msg_addr;
    word_t msg_data;
    addr_t out_addr;
    byte_t out_data;
    logic  busy;
    logic  done;

    byte_t ct_bytes [2 * n];
    word_t msg_words [n / 32];
    byte_t exp_out [n_out];
    word_t rng_state;

    encrypter #(.N(n)) dut (
        .clk(clk), .rst(rst), .start(start),
        .ct_we(ct_we), .ct_addr(ct_addr), .ct_data(ct_data),
        .msg_we(msg_we), .msg_addr(msg_addr), .msg_data(msg_data),
        .out_addr(out_addr), .out_data(out_data), .busy(busy), .done(done)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    function automatic word_t next_random();
        word_t x;
        x = rng_state;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rng_state = x;
        return x;
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_byte(input string name, input byte_t got, input byte_t exp);
        if (got !== exp) report_failure($sformatf("ERR %s got 0x%02h exp 0x%02h", name, got, exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) report_failure($sformatf("ERR %s got 0x%0h exp 0x%0h", name, got, exp));
    endtask

    task automatic clear_data();
        foreach (ct_bytes[i]) ct_bytes[i] = '0;
        foreach (msg_words[i]) msg_words[i] = '0;
    endtask

    task automatic random_data();
        foreach (ct_bytes[i]) ct_bytes[i] = byte_t'(next_random());
        foreach (msg_words[i]) msg_words[i] = next_random();
    endtask

    // host writes, one per cycle
    task automatic load_inputs();
        for (int i = 0; i < 2 * n; i++) begin
            ct_we = 1'b1;
            ct_addr = addr_t'(i);
            ct_data = ct_bytes[i];
            next_cycle();
        end
        ct_we = 1'b0;
        for (int i = 0; i < n / 32; i++) begin
            msg_we = 1'b1;
            msg_addr = addr_t'(i);
            msg_data = msg_words[i];
            next_cycle();
        end
        msg_we = 1'b0;
    endtask

    // reference model of decode, encode, add and compress
    task automatic build_expected();
        int unsigned raw;
        int unsigned u;
        int unsigned m;
        int unsigned c;
        int unsigned pos;
        foreach (exp_out[k]) exp_out[k] = '0;
        for (int i = 0; i < n; i++) begin
            raw = {ct_bytes[2 * i + 1], ct_bytes[2 * i]};
            raw = raw & 32'h3fff;
            u = raw % q;
            m = msg_words[i / 32][i % 32] ? q_half : 0;
            c = ((8 * ((u + m) % q) + q_half) / q) % 8;
            for (int b = 0; b < comp_bits; b++) begin
                pos = comp_bits * i + b;   // lsb first stream
                exp_out[pos / 8][pos % 8] = c[b];
            end
        end
    endtask

    task automatic start_run();
        check_bit("busy", busy, 1'b0);
        start = 1'b1;
        next_cycle();
        start = 1'b0;
        check_bit("busy", busy, 1'b1);
    endtask

    task automatic wait_for_done();
        int cycles;
        cycles = 0;
        while (done !== 1'b1) begin
            if (cycles >= 40 * n) report_failure("timeout while waiting for done from the DUT");
            next_cycle();
            cycles++;
        end
        next_cycle();
        check_bit("done", done, 1'b0);
        check_bit("busy", busy, 1'b0);
    endtask

    // read data one cycle after the address
    task automatic compare_output();
        for (int k = 0; k < n_out; k++) begin
            out_addr = addr_t'(k);
            next_cycle();
            check_byte($sformatf("out_data[%0d]", k), out_data, exp_out[k]);
        end
    endtask

    task automatic run_and_compare();
        load_inputs();
        start_run();
        wait_for_done();
        compare_output();
    endtask

    ////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////

    task automatic test_reset_state();
        check_bit("busy", busy, 1'b0);
        check_bit("done", done, 1'b0);
        clear_data();
        load_inputs();
        start_run();
        wait_for_done();
    endtask

    task automatic test_zero_input();
        clear_data();
        foreach (exp_out[k]) exp_out[k] = '0;
        run_and_compare();
    endtask

    task automatic test_ones_message();
        byte_t pattern [3];
        pattern = '{8'h24, 8'h49, 8'h92};   // level 4 = 3'b100 repeated
        clear_data();
        foreach (msg_words[i]) msg_words[i] = '1;
        foreach (exp_out[k]) exp_out[k] = pattern[k % 3];
        run_and_compare();
    endtask

    task automatic test_random();
        random_data();
        ct_bytes[0] = 8'hff;   // raw 0x3fff
        ct_bytes[1] = 8'hff;
        ct_bytes[2] = 8'h01;   // raw exactly q
        ct_bytes[3] = 8'h30;
        ct_bytes[4] = 8'h00;   // q - 1 plus q_half wraps
        ct_bytes[5] = 8'h30;
        msg_words[0][2] = 1'b1;
        build_expected();
        run_and_compare();
    endtask

    task automatic test_busy_restart();
        int extra;
        random_data();
        build_expected();
        load_inputs();
        start_run();
        repeat (10) next_cycle();
        start = 1'b1;   // ignored while busy
        next_cycle();
        start = 1'b0;
        check_bit("busy", busy, 1'b1);
        wait_for_done();
        extra = 0;
        for (int i = 0; i < 8 * n; i++) begin
            next_cycle();
            if (done) extra++;
        end
        if (extra != 0) report_failure("start during busy produced an extra done pulse");
        compare_output();
        random_data();
        build_expected();
        run_and_compare();
    endtask

    initial begin
        rst = 1'b1;
        start = 1'b0;
        ct_we = 1'b0;
        ct_addr = '0;
        ct_data = '0;
        msg_we = 1'b0;
        msg_addr = '0;
        msg_data = '0;
        out_addr = '0;
        rng_state = 32'd8918;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        test_reset_state();
        test_zero_input();
        test_ones_message();
        test_random();
        test_busy_restart();
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb_encrypter_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module tb_encrypter_assertions
    import encrypt_pkg::*;
(
    input wire logic       clk,
    input wire logic       rst,
    input var  seq_state_t state,
    input wire logic       start_decode,
    input wire logic       start_encode,
    input wire logic       start_add,
    input wire logic       start_pack,
    input wire logic       done
);

    done_one_cycle: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else $error("done held longer than one cycle");

    done_in_finish: assert property (@(posedge clk) disable iff (rst)
        done |-> state == seq_finish)
        else $error("done outside the finish phase");

    // strobes leave idle together with the state change
    no_strobe_in_idle: assert property (@(posedge clk) disable iff (rst)
        state == seq_idle |-> !(start_decode || start_encode || start_add || start_pack))
        else $error("start strobe while the sequencer is idle");

endmodule

bind encrypt_sequencer tb_encrypter_assertions seq_checks (
    .clk(clk), .rst(rst), .state(state),
    .start_decode(start_decode), .start_encode(start_encode),
    .start_add(start_add), .start_pack(start_pack), .done(done)
);

`default_nettype wire
